// ==== hw/fpu_defines.svh ====
// field widths, bias, unit round counts and the host register map
// include wherever one of these constants is needed
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// ieee-754 single precision fields
`define FPU_EXP_W     8
`define FPU_FRAC_W    23
`define FPU_MANT_W    24
`define FPU_EXP_BIAS  8'd127
`define FPU_EXP_INF   8'd255

// add/shift rounds and quotient bits of the iterative units
`define FPU_MUL_ITER  5'd24
`define FPU_DIV_ITER  5'd25

// byte addresses on the host port
`define FPU_ADDR_A0    4'd0
`define FPU_ADDR_B0    4'd4
`define FPU_ADDR_OP    4'd8
`define FPU_ADDR_START 4'd9
`define FPU_ADDR_RES0  4'd9

`endif

// ==== hw/fpu_pkg.sv ====
// shared types of the fp coprocessor
// blocks refer to them through fpu_pkg:: scoped names
`include "fpu_defines.svh"

package fpu_pkg;

  // host writes the operation code as data bit 0
  typedef enum logic {
    op_mul = 1'b0,
    op_div = 1'b1
  } fpu_op_e;

  // single precision word, sign in the msb
  typedef struct packed {
    logic                   sign;
    logic [`FPU_EXP_W-1:0]  exp;
    logic [`FPU_FRAC_W-1:0] frac;
  } fp_fields_t;

  // register file sees raw bytes
  // units decode the same word into fields
  typedef union packed {
    logic [31:0] raw;
    fp_fields_t  f;
  } fp_word_u;

  // both operands travel together to a unit
  typedef struct packed {
    fp_word_u a;
    fp_word_u b;
  } fpu_operands_t;

  // result word qualified by valid
  typedef struct packed {
    fp_word_u word;
    logic     valid;
  } fpu_result_t;

endpackage

// ==== hw/fpu_bus_regs.sv ====
// host register file of the coprocessor
// byte lane writes, combinational reads, start request toward the sequencer
`timescale 1ns/10ps
`include "fpu_defines.svh"

module fpu_bus_regs (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   cs,
  input  logic                   rd,
  input  logic                   wr,
  input  logic [3:0]             addr,
  input  logic [7:0]             databus_in,
  output logic [7:0]             databus_out,
  output fpu_pkg::fpu_operands_t operands,
  output fpu_pkg::fpu_op_e       op,
  output logic                   start_req,
  input  logic                   start_clr,
  input  logic                   busy,
  input  fpu_pkg::fpu_result_t   result
);

  fpu_pkg::fpu_operands_t opnd_q;
  fpu_pkg::fp_word_u      res_q;
  logic                   host_wr;
  logic                   host_rd;

  // strobes are active low
  assign host_wr  = !cs && !wr;
  assign host_rd  = !cs && !rd;
  assign operands = opnd_q;

  // --------------------------------------------------
  // write side
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      // both operands come up as 1.0
      opnd_q.a.raw <= {1'b0, `FPU_EXP_BIAS, {`FPU_FRAC_W{1'b0}}};
      opnd_q.b.raw <= {1'b0, `FPU_EXP_BIAS, {`FPU_FRAC_W{1'b0}}};
      op           <= fpu_pkg::op_mul;
      start_req    <= 1'b0;
      res_q        <= '0;
    end else begin
      if (host_wr) begin
        case (addr)
          `FPU_ADDR_A0:        opnd_q.a.raw[7:0]   <= databus_in;
          `FPU_ADDR_A0 + 4'd1: opnd_q.a.raw[15:8]  <= databus_in;
          `FPU_ADDR_A0 + 4'd2: opnd_q.a.raw[23:16] <= databus_in;
          `FPU_ADDR_A0 + 4'd3: opnd_q.a.raw[31:24] <= databus_in;
          `FPU_ADDR_B0:        opnd_q.b.raw[7:0]   <= databus_in;
          `FPU_ADDR_B0 + 4'd1: opnd_q.b.raw[15:8]  <= databus_in;
          `FPU_ADDR_B0 + 4'd2: opnd_q.b.raw[23:16] <= databus_in;
          `FPU_ADDR_B0 + 4'd3: opnd_q.b.raw[31:24] <= databus_in;
          `FPU_ADDR_OP:        op <= fpu_pkg::fpu_op_e'(databus_in[0]);
          // start only counts when no command is running
          `FPU_ADDR_START:     start_req <= start_req || !busy;
          default: ;
        endcase
      end
      // sequencer took the request
      if (start_clr)
        start_req <= 1'b0;
      // finished result also lands in operand a for chaining
      if (result.valid) begin
        res_q    <= result.word;
        opnd_q.a <= result.word;
      end
    end
  end

  // --------------------------------------------------
  // read side, bus idles at zero
  always_comb begin
    databus_out = 8'h00;
    if (host_rd) begin
      case (addr)
        `FPU_ADDR_A0:          databus_out = opnd_q.a.raw[7:0];
        `FPU_ADDR_A0 + 4'd1:   databus_out = opnd_q.a.raw[15:8];
        `FPU_ADDR_A0 + 4'd2:   databus_out = opnd_q.a.raw[23:16];
        `FPU_ADDR_A0 + 4'd3:   databus_out = opnd_q.a.raw[31:24];
        `FPU_ADDR_B0:          databus_out = opnd_q.b.raw[7:0];
        `FPU_ADDR_B0 + 4'd1:   databus_out = opnd_q.b.raw[15:8];
        `FPU_ADDR_B0 + 4'd2:   databus_out = opnd_q.b.raw[23:16];
        `FPU_ADDR_B0 + 4'd3:   databus_out = opnd_q.b.raw[31:24];
        `FPU_ADDR_OP:          databus_out = {7'd0, op};
        `FPU_ADDR_RES0:        databus_out = res_q.raw[7:0];
        `FPU_ADDR_RES0 + 4'd1: databus_out = res_q.raw[15:8];
        `FPU_ADDR_RES0 + 4'd2: databus_out = res_q.raw[23:16];
        `FPU_ADDR_RES0 + 4'd3: databus_out = res_q.raw[31:24];
        default:               databus_out = 8'h00;
      endcase
    end
  end

  // a start write during a command never raises a new request
  assert property (@(posedge clk) disable iff (arst)
    $rose(start_req) |-> !$past(busy));

endmodule

// ==== hw/fpu_sequencer.sv ====
// command FSM of the coprocessor
// picks a unit from op, runs the req/ack exchange, drives busy and cmd_end
`timescale 1ns/10ps

module fpu_sequencer (
  input  logic                 clk,
  input  logic                 arst,
  input  logic                 start_req,
  input  fpu_pkg::fpu_op_e     op,
  input  logic                 end_ack,
  output logic                 start_clr,
  output logic                 busy,
  output logic                 cmd_end,
  output logic                 mul_req,
  output logic                 div_req,
  input  logic                 mul_ack,
  input  logic                 div_ack,
  input  fpu_pkg::fpu_result_t mul_res,
  input  fpu_pkg::fpu_result_t div_res,
  output fpu_pkg::fpu_result_t result
);

  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_DISPATCH = 2'd1;
  localparam logic [1:0] ST_FINISH   = 2'd2;
  localparam logic [1:0] ST_WAIT_ACK = 2'd3;

  logic [1:0]           state_q;
  fpu_pkg::fpu_op_e     op_q;
  logic                 sel_ack;
  fpu_pkg::fpu_result_t sel_res;

  // unit chosen for the running command
  assign sel_ack   = (op_q == fpu_pkg::op_div) ? div_ack : mul_ack;
  assign sel_res   = (op_q == fpu_pkg::op_div) ? div_res : mul_res;
  // request is consumed as we leave idle
  assign start_clr = (state_q == ST_IDLE) && start_req;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state_q <= ST_IDLE;
      op_q    <= fpu_pkg::op_mul;
      busy    <= 1'b0;
      cmd_end <= 1'b0;
      mul_req <= 1'b0;
      div_req <= 1'b0;
      result  <= '0;
    end else begin
      // valid is a single cycle pulse
      result.valid <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_req) begin
            op_q    <= op;
            mul_req <= (op == fpu_pkg::op_mul);
            div_req <= (op == fpu_pkg::op_div);
            busy    <= 1'b1;
            state_q <= ST_DISPATCH;
          end
        end
        // unit holds its word stable while ack is high
        ST_DISPATCH: begin
          if (sel_ack) begin
            mul_req <= 1'b0;
            div_req <= 1'b0;
            result  <= sel_res;
            state_q <= ST_FINISH;
          end
        end
        // wait for ack to drop, result is stored by now
        ST_FINISH: begin
          if (!sel_ack) begin
            cmd_end <= 1'b1;
            state_q <= ST_WAIT_ACK;
          end
        end
        // host holds end_ack low to keep cmd_end up
        default: begin
          if (end_ack) begin
            busy    <= 1'b0;
            cmd_end <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // one unit at a time
  assert property (@(posedge clk) disable iff (arst) !(mul_req && div_req));

endmodule

// ==== hw/fpu_mul_unit.sv ====
// iterative single precision multiplier, truncating
// latches operands on a rising req, raises ack with the result held
`timescale 1ns/10ps
`include "fpu_defines.svh"

module fpu_mul_unit (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   req,
  input  fpu_pkg::fpu_operands_t operands,
  output logic                   ack,
  output fpu_pkg::fpu_result_t   res
);

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_ADD   = 3'd1;
  localparam logic [2:0] ST_SHIFT = 3'd2;
  localparam logic [2:0] ST_NORM  = 3'd3;
  localparam logic [2:0] ST_DONE  = 3'd4;

  logic [2:0]               state_q;
  logic [4:0]               cnt_q;
  fpu_pkg::fpu_operands_t   opnd_q;
  // product in the upper half, multiplier shifting out below
  logic [2*`FPU_MANT_W:0]   pm_q;
  fpu_pkg::fp_word_u        word_q;
  logic [`FPU_MANT_W-1:0]   ma;
  logic [`FPU_MANT_W-1:0]   mant;
  logic [9:0]               exp_sum;
  logic                     any_zero;

  // hidden one, exponent zero flushes to zero
  assign ma       = {opnd_q.a.f.exp != '0, opnd_q.a.f.frac};
  assign any_zero = (opnd_q.a.f.exp == '0) || (opnd_q.b.f.exp == '0);
  // product in [1,4), bit 47 set means one extra exponent step
  assign mant     = pm_q[47] ? pm_q[47:24] : pm_q[46:23];
  assign exp_sum  = {2'b00, opnd_q.a.f.exp} + {2'b00, opnd_q.b.f.exp}
                  - {2'b00, `FPU_EXP_BIAS} + {9'd0, pm_q[47]};

  // --------------------------------------------------
  // control
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req) begin
            cnt_q   <= '0;
            state_q <= ST_ADD;
          end
        end
        ST_ADD: begin
          cnt_q   <= cnt_q + 5'd1;
          state_q <= ST_SHIFT;
        end
        ST_SHIFT: state_q <= (cnt_q == `FPU_MUL_ITER) ? ST_NORM : ST_ADD;
        ST_NORM:  state_q <= ST_DONE;
        // hold ack until the sequencer drops req
        ST_DONE: begin
          if (!req)
            state_q <= ST_IDLE;
        end
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  always_ff @(posedge clk) begin
    case (state_q)
      ST_IDLE: begin
        if (req) begin
          opnd_q <= operands;
          pm_q   <= {{(`FPU_MANT_W+1){1'b0}}, operands.b.f.exp != '0, operands.b.f.frac};
        end
      end
      // add multiplicand when the multiplier lsb is set
      ST_ADD: begin
        if (pm_q[0])
          pm_q[48:24] <= pm_q[48:24] + {1'b0, ma};
      end
      ST_SHIFT: pm_q <= pm_q >> 1;
      ST_NORM: begin
        word_q.f.sign <= opnd_q.a.f.sign ^ opnd_q.b.f.sign;
        word_q.f.exp  <= any_zero ? '0 : exp_sum[7:0];
        word_q.f.frac <= any_zero ? '0 : mant[`FPU_FRAC_W-1:0];
      end
      default: ;
    endcase
  end

  assign ack       = (state_q == ST_DONE);
  assign res.word  = word_q;
  assign res.valid = ack;

  // four-phase order, ack only drops after req
  assert property (@(posedge clk) disable iff (arst) $fell(ack) |-> !$past(req));

endmodule

// ==== hw/fpu_div_unit.sv ====
// iterative single precision divider, restoring, truncating
// latches operands on a rising req, raises ack with the result held
`timescale 1ns/10ps
`include "fpu_defines.svh"

module fpu_div_unit (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   req,
  input  fpu_pkg::fpu_operands_t operands,
  output logic                   ack,
  output fpu_pkg::fpu_result_t   res
);

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_SUB   = 3'd1;
  localparam logic [2:0] ST_SET   = 3'd2;
  localparam logic [2:0] ST_SHIFT = 3'd3;
  localparam logic [2:0] ST_NORM  = 3'd4;
  localparam logic [2:0] ST_DONE  = 3'd5;

  logic [2:0]             state_q;
  logic [4:0]             cnt_q;
  fpu_pkg::fpu_operands_t opnd_q;
  // partial remainder, stays below twice the divisor
  logic [`FPU_MANT_W:0]   rem_q;
  // trial subtraction, msb is the borrow
  logic [`FPU_MANT_W+1:0] diff_q;
  logic [`FPU_MANT_W:0]   q_q;
  fpu_pkg::fp_word_u      word_q;
  logic [`FPU_MANT_W-1:0] ma_in;
  logic [`FPU_MANT_W-1:0] mb;
  logic [`FPU_MANT_W-1:0] mant;
  logic [9:0]             exp_dif;

  // dividend taken straight from the port on the load cycle
  assign ma_in   = {operands.a.f.exp != '0, operands.a.f.frac};
  assign mb      = {opnd_q.b.f.exp != '0, opnd_q.b.f.frac};
  // quotient in (1/2,2), one exponent less when bit 24 is clear
  assign mant    = q_q[24] ? q_q[24:1] : q_q[23:0];
  assign exp_dif = {2'b00, opnd_q.a.f.exp} - {2'b00, opnd_q.b.f.exp}
                 + {2'b00, `FPU_EXP_BIAS} - {9'd0, !q_q[24]};

  // --------------------------------------------------
  // control, three cycles per quotient bit
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req) begin
            cnt_q   <= '0;
            state_q <= ST_SUB;
          end
        end
        ST_SUB: state_q <= ST_SET;
        ST_SET: begin
          cnt_q   <= cnt_q + 5'd1;
          state_q <= ST_SHIFT;
        end
        ST_SHIFT: state_q <= (cnt_q == `FPU_DIV_ITER) ? ST_NORM : ST_SUB;
        ST_NORM:  state_q <= ST_DONE;
        ST_DONE: begin
          if (!req)
            state_q <= ST_IDLE;
        end
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // datapath
  always_ff @(posedge clk) begin
    case (state_q)
      ST_IDLE: begin
        if (req) begin
          opnd_q <= operands;
          rem_q  <= {1'b0, ma_in};
        end
      end
      ST_SUB: diff_q <= {1'b0, rem_q} - {2'b00, mb};
      // no borrow keeps the difference and shifts in a one
      ST_SET: begin
        if (!diff_q[`FPU_MANT_W+1])
          rem_q <= diff_q[`FPU_MANT_W:0];
        q_q <= {q_q[`FPU_MANT_W-1:0], !diff_q[`FPU_MANT_W+1]};
      end
      ST_SHIFT: rem_q <= {rem_q[`FPU_MANT_W-1:0], 1'b0};
      ST_NORM: begin
        word_q.f.sign <= opnd_q.a.f.sign ^ opnd_q.b.f.sign;
        if (opnd_q.a.f.exp == '0) begin
          word_q.f.exp  <= '0;
          word_q.f.frac <= '0;
        end else if (opnd_q.b.f.exp == '0) begin
          // divide by zero gives infinity
          word_q.f.exp  <= `FPU_EXP_INF;
          word_q.f.frac <= '0;
        end else begin
          word_q.f.exp  <= exp_dif[7:0];
          word_q.f.frac <= mant[`FPU_FRAC_W-1:0];
        end
      end
      default: ;
    endcase
  end

  assign ack       = (state_q == ST_DONE);
  assign res.word  = word_q;
  assign res.valid = ack;

  // four-phase order, ack only drops after req
  assert property (@(posedge clk) disable iff (arst) $fell(ack) |-> !$past(req));

endmodule

// ==== hw/fpu_top.sv ====
// top level of the fp coprocessor
// host register port in front, sequencer and the two iterative units behind it
`timescale 1ns/10ps

module fpu_top (
  input  logic       clk,
  input  logic       arst,
  input  logic       cs,
  input  logic       rd,
  input  logic       wr,
  input  logic [3:0] addr,
  input  logic [7:0] databus_in,
  input  logic       end_ack,
  output logic [7:0] databus_out,
  output logic       cmd_end,
  output logic       busy
);

  fpu_pkg::fpu_operands_t operands;
  fpu_pkg::fpu_op_e       op;
  fpu_pkg::fpu_result_t   result;
  fpu_pkg::fpu_result_t   mul_res;
  fpu_pkg::fpu_result_t   div_res;
  logic                   start_req;
  logic                   start_clr;
  logic                   mul_req;
  logic                   mul_ack;
  logic                   div_req;
  logic                   div_ack;

  fpu_bus_regs regs_i (
    .clk, .arst, .cs, .rd, .wr, .addr, .databus_in, .databus_out,
    .operands, .op, .start_req, .start_clr, .busy, .result
  );

  fpu_sequencer seq_i (
    .clk, .arst, .start_req, .op, .end_ack, .start_clr, .busy, .cmd_end,
    .mul_req, .div_req, .mul_ack, .div_ack, .mul_res, .div_res, .result
  );

  // both units share the operand bus
  fpu_mul_unit mul_i (.clk, .arst, .req(mul_req), .operands, .ack(mul_ack), .res(mul_res));
  fpu_div_unit div_i (.clk, .arst, .req(div_req), .operands, .ack(div_ack), .res(div_res));

endmodule

// ==== tb/fpu_tb.sv ====
// testbench of the fp coprocessor top level
// random and corner multiplies and divides over the byte port, checked by assertions
`timescale 1ns/10ps
`include "fpu_defines.svh"

module fpu_tb;

  // reset, 16 mul, 16 div, 4 zero cases, chain pair, back-pressure
  localparam int NUM_TESTS = 40;

  logic        clk;
  logic        arst;
  logic        cs;
  logic        rd;
  logic        wr;
  logic [3:0]  addr;
  logic [7:0]  databus_in;
  logic        end_ack;
  logic [7:0]  databus_out;
  logic        cmd_end;
  logic        busy;
  // checker enables and the byte a read should return
  logic        chk_en;
  logic        hold_chk;
  logic        idle_chk;
  logic [7:0]  exp_byte;
  logic [31:0] lfsr_q = 32'hc71969c8;
  logic [31:0] last_res;
  int          err_cnt = 0;
  int          n_pass = 0;
  int          n_fail = 0;

  fpu_top dut_i (.clk, .arst, .cs, .rd, .wr, .addr, .databus_in, .end_ack,
                 .databus_out, .cmd_end, .busy);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // run ends here if a command never completes
  initial begin
    #(NUM_TESTS * 200 * 40);
    $display("watchdog expired, a command did not complete in time");
    $display("ERRORS FOUND");
    $finish;
  end

  // --------------------------------------------------
  // checkers
  assert property (@(posedge clk) disable iff (arst) chk_en |-> databus_out == exp_byte)
    else begin
      $display("Fail %0t read of addr %0d gave %h, expected %h",
               $time, $sampled(addr), $sampled(databus_out), $sampled(exp_byte));
      err_cnt = err_cnt + 1;
    end

  // back-pressure keeps both flags up
  assert property (@(posedge clk) disable iff (arst) hold_chk |-> busy && cmd_end)
    else begin
      $display("Fail %0t busy or cmd_end dropped while end_ack was low", $time);
      err_cnt = err_cnt + 1;
    end

  assert property (@(posedge clk) disable iff (arst) idle_chk |-> !busy && !cmd_end)
    else begin
      $display("Fail %0t busy or cmd_end high while no command should run", $time);
      err_cnt = err_cnt + 1;
    end

  // --------------------------------------------------
  // stimulus source, x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[31]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // exponent kept in 64..190
  function automatic logic [31:0] rand_operand();
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] f;
    s = take_bits(1);
    e = take_bits(7);
    f = take_bits(23);
    return {s[0], 8'd64 + 8'(e % 127), f[22:0]};
  endfunction

  // --------------------------------------------------
  // reference model, truncating
  function automatic logic [31:0] model_mul(input logic [31:0] a, input logic [31:0] b);
    logic        s;
    logic [47:0] p;
    logic [9:0]  e;
    s = a[31] ^ b[31];
    if (a[30:23] == 8'd0 || b[30:23] == 8'd0)
      return {s, 31'd0};
    p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
    e = 10'(a[30:23]) + 10'(b[30:23]) - 10'd127;
    if (p[47])
      return {s, 8'(e + 10'd1), p[46:24]};
    return {s, e[7:0], p[45:23]};
  endfunction

  function automatic logic [31:0] model_div(input logic [31:0] a, input logic [31:0] b);
    logic        s;
    logic [47:0] q;
    logic [9:0]  e;
    s = a[31] ^ b[31];
    if (a[30:23] == 8'd0)
      return {s, 31'd0};
    // zero divisor, signed infinity
    if (b[30:23] == 8'd0)
      return {s, 8'hff, 23'd0};
    q = {1'b1, a[22:0], 24'd0} / {24'd0, 1'b1, b[22:0]};
    e = 10'(a[30:23]) - 10'(b[30:23]) + 10'd127;
    if (q[24])
      return {s, e[7:0], q[23:1]};
    return {s, 8'(e - 10'd1), q[22:0]};
  endfunction

  // --------------------------------------------------
  // host bus
  task automatic bus_write(input logic [3:0] a, input logic [7:0] d);
    @(posedge clk);
    #2;
    cs = 1'b0;
    wr = 1'b0;
    addr = a;
    databus_in = d;
    @(posedge clk);
    #2;
    cs = 1'b1;
    wr = 1'b1;
  endtask

  task automatic check_read(input logic [3:0] a, input logic [7:0] e);
    @(posedge clk);
    #2;
    cs = 1'b0;
    rd = 1'b0;
    addr = a;
    exp_byte = e;
    chk_en = 1'b1;
    @(posedge clk);
    #2;
    cs = 1'b1;
    rd = 1'b1;
    chk_en = 1'b0;
  endtask

  // little endian byte lanes
  task automatic write_word(input logic [3:0] base, input logic [31:0] w);
    for (int i = 0; i < 4; i++)
      bus_write(base + 4'(i), w[8*i +: 8]);
  endtask

  task automatic check_word(input logic [3:0] base, input logic [31:0] w);
    for (int i = 0; i < 4; i++)
      check_read(base + 4'(i), w[8*i +: 8]);
  endtask

  // hold optionally keeps end_ack low and tries a second start
  task automatic release_cmd(input logic hold);
    if (hold) begin
      hold_chk = 1'b1;
      bus_write(`FPU_ADDR_START, 8'h00);
      repeat (18) begin
        @(posedge clk);
        #2;
      end
      hold_chk = 1'b0;
    end
    end_ack = 1'b1;
    @(posedge clk);
    #2;
    end_ack = 1'b0;
    idle_chk = 1'b1;
    repeat (4) begin
      @(posedge clk);
      #2;
    end
    idle_chk = 1'b0;
  endtask

  task automatic report(input string name, input int e0);
    if (err_cnt == e0) begin
      n_pass++;
      $display("test %s passed", name);
    end else begin
      n_fail++;
      $display("test %s failed with %0d errors", name, err_cnt - e0);
    end
  endtask

  // wr_a low leaves operand a as the previous result
  task automatic run_test(input string name, input fpu_pkg::fpu_op_e o, input logic [31:0] a,
                          input logic [31:0] b, input logic wr_a, input logic hold);
    int          e0;
    logic [31:0] want;
    e0 = err_cnt;
    want = (o == fpu_pkg::op_mul) ? model_mul(a, b) : model_div(a, b);
    if (wr_a)
      write_word(`FPU_ADDR_A0, a);
    write_word(`FPU_ADDR_B0, b);
    bus_write(`FPU_ADDR_OP, {7'd0, o});
    bus_write(`FPU_ADDR_START, 8'h00);
    while (!cmd_end) begin
      @(posedge clk);
      #2;
    end
    release_cmd(hold);
    check_word(`FPU_ADDR_RES0, want);
    check_word(`FPU_ADDR_A0, want);
    last_res = want;
    report(name, e0);
  endtask

  // --------------------------------------------------
  initial begin
    logic [31:0] a;
    logic [31:0] b;
    int          e0;
    {cs, rd, wr} = 3'b111;
    addr = 4'd0;
    databus_in = 8'h00;
    end_ack = 1'b0;
    {chk_en, hold_chk, idle_chk} = 3'b000;
    exp_byte = 8'h00;
    last_res = '0;
    arst = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    arst = 1'b0;
    e0 = err_cnt;
    idle_chk = 1'b1;
    check_word(`FPU_ADDR_A0, 32'h3f800000);
    check_word(`FPU_ADDR_RES0, 32'h00000000);
    idle_chk = 1'b0;
    report("reset state", e0);
    for (int i = 0; i < 16; i++)
      run_test($sformatf("mul %0d", i), fpu_pkg::op_mul, rand_operand(), rand_operand(), 1, 0);
    for (int i = 0; i < 16; i++)
      run_test($sformatf("div %0d", i), fpu_pkg::op_div, rand_operand(), rand_operand(), 1, 0);
    // zero operands, exponent field zero
    run_test("mul zero a", fpu_pkg::op_mul, 32'h00000000, rand_operand(), 1, 0);
    run_test("mul zero b", fpu_pkg::op_mul, rand_operand(), 32'h80000000, 1, 0);
    run_test("div zero dividend", fpu_pkg::op_div, 32'h80001234, rand_operand(), 1, 0);
    run_test("div by zero", fpu_pkg::op_div, rand_operand(), 32'h00000000, 1, 0);
    // chained multiply on the stored result
    a = rand_operand();
    b = rand_operand();
    run_test("chain seed", fpu_pkg::op_mul, {a[31], 8'd127, a[22:0]},
             {b[31], 8'd128, b[22:0]}, 1, 0);
    run_test("chain mul", fpu_pkg::op_mul, last_res, rand_operand(), 0, 0);
    run_test("end_ack held low", fpu_pkg::op_div, rand_operand(), rand_operand(), 1, 1);
    $display("%0d tests passed, %0d tests failed, %0d errors", n_pass, n_fail, err_cnt);
    if (err_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+hw
hw/fpu_pkg.sv
hw/fpu_bus_regs.sv
hw/fpu_sequencer.sv
hw/fpu_mul_unit.sv
hw/fpu_div_unit.sv
hw/fpu_top.sv
tb/fpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with verilator, run, then decide pass or fail from the log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module fpu_tb \
  -Mdir obj_dir -o fpu_sim > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/fpu_sim > sim.log 2>&1
cat sim.log
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
